//--- logic/board_cfg_pkg.sv
// Board control shell platform constants for clocking, RTC, fan PWM and bus widths
package board_cfg_pkg;

  //////////////////////////////////////////////////////////////////////
  // Register bus
  //////////////////////////////////////////////////////////////////////

  // Byte address into the register block
  localparam int unsigned AddrWidth = 8;
  localparam int unsigned DataWidth = 32;

  //////////////////////////////////////////////////////////////////////
  // RTC divider
  //////////////////////////////////////////////////////////////////////

  // soc_clk cycles between RTC toggles
  // The full RTC period is twice this
  localparam int unsigned RtcHalfPeriod = 25;
  localparam int unsigned RtcCntWidth   = 16;

  //////////////////////////////////////////////////////////////////////
  // Fan PWM
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned FanDutyWidth  = 4;
  // soc_clk cycles per PWM step
  localparam int unsigned FanPrescale   = 4;
  localparam int unsigned FanPrescWidth = $clog2(FanPrescale);

  //////////////////////////////////////////////////////////////////////
  // Boot mode
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned BootModeWidth = 2;

endpackage

//--- logic/board_regs_pkg.sv
// Board control shell register map, bus response codes and fixed data words
package board_regs_pkg;

  import board_cfg_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Register map
  //////////////////////////////////////////////////////////////////////

  // Identity word, read only
  localparam logic [AddrWidth-1:0] RegIdOffs   = 8'h00;
  // Boot select in bit 2, mode in bits 1:0
  localparam logic [AddrWidth-1:0] RegBootOffs = 8'h04;
  // Fan override in bit 4, duty in bits 3:0
  localparam logic [AddrWidth-1:0] RegFanOffs  = 8'h08;
  // RTC edge counter, any write clears it
  localparam logic [AddrWidth-1:0] RegRtcOffs  = 8'h0C;

  //////////////////////////////////////////////////////////////////////
  // AXI response codes
  //////////////////////////////////////////////////////////////////////

  localparam logic [1:0] RespOkay   = 2'b00;
  localparam logic [1:0] RespSlvErr = 2'b10;

  //////////////////////////////////////////////////////////////////////
  // Fixed words
  //////////////////////////////////////////////////////////////////////

  // Board identity
  localparam logic [DataWidth-1:0] BoardIdWord = 32'h5ABC_0001;

  // Returned on reads from unmapped offsets
  localparam logic [DataWidth-1:0] ErrWord = 32'hBADCAB1E;

endpackage

//--- logic/axil_slave_port.sv
// AXI4-Lite slave port turning bus transactions into single-cycle register accesses
`timescale 1ns/1ps

module axil_slave_port
  import board_cfg_pkg::*;
  import board_regs_pkg::*;
(
  input  logic                   soc_clk,
  input  logic                   rst_n,
  // Write address and data
  input  logic [AddrWidth-1:0]   axil_awaddr_i,
  input  logic                   axil_awvalid_i,
  output logic                   axil_awready_o,
  input  logic [DataWidth-1:0]   axil_wdata_i,
  input  logic [DataWidth/8-1:0] axil_wstrb_i,
  input  logic                   axil_wvalid_i,
  output logic                   axil_wready_o,
  // Write response
  output logic [1:0]             axil_bresp_o,
  output logic                   axil_bvalid_o,
  input  logic                   axil_bready_i,
  // Read address and data
  input  logic [AddrWidth-1:0]   axil_araddr_i,
  input  logic                   axil_arvalid_i,
  output logic                   axil_arready_o,
  output logic [DataWidth-1:0]   axil_rdata_o,
  output logic [1:0]             axil_rresp_o,
  output logic                   axil_rvalid_o,
  input  logic                   axil_rready_i,
  // Register access
  output logic                   acc_valid_o,
  output logic                   acc_we_o,
  output logic [AddrWidth-1:0]   acc_addr_o,
  output logic [DataWidth-1:0]   acc_wdata_o,
  input  logic [DataWidth-1:0]   acc_rdata_i,
  input  logic                   acc_err_i
);

  logic                 wr_accept;
  logic                 rd_accept;
  logic                 bvalid_q;
  logic                 rvalid_q;
  logic [1:0]           bresp_q;
  logic [1:0]           rresp_q;
  logic [DataWidth-1:0] rdata_q;

  // AW and W are taken together, and a write beats a read in the same cycle
  assign wr_accept = axil_awvalid_i & axil_wvalid_i & ~bvalid_q;
  assign rd_accept = axil_arvalid_i & ~rvalid_q & ~wr_accept;

  assign axil_awready_o = wr_accept;
  assign axil_wready_o  = wr_accept;
  assign axil_arready_o = ~rvalid_q & ~wr_accept;

  // Byte 0 holds every writable field, so strobe 0 alone enables the write
  assign acc_valid_o = wr_accept | rd_accept;
  assign acc_we_o    = wr_accept & axil_wstrb_i[0];
  assign acc_addr_o  = wr_accept ? axil_awaddr_i : axil_araddr_i;
  assign acc_wdata_o = axil_wdata_i;

  //////////////////////////////////////////////////////////////////////
  // Response channels
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      if (wr_accept) begin
        bvalid_q <= 1'b1;
      end else if (axil_bready_i) begin
        bvalid_q <= 1'b0;
      end
      if (rd_accept) begin
        rvalid_q <= 1'b1;
      end else if (axil_rready_i) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  // Payload only loads on acceptance and holds under back-pressure
  always_ff @(posedge soc_clk) begin
    if (wr_accept) begin
      bresp_q <= acc_err_i ? RespSlvErr : RespOkay;
    end
    if (rd_accept) begin
      rresp_q <= acc_err_i ? RespSlvErr : RespOkay;
      rdata_q <= acc_rdata_i;
    end
  end

  assign axil_bvalid_o = bvalid_q;
  assign axil_bresp_o  = bresp_q;
  assign axil_rvalid_o = rvalid_q;
  assign axil_rresp_o  = rresp_q;
  assign axil_rdata_o  = rdata_q;

endmodule

//--- logic/periph_decoder.sv
// Register address decoder with write enables, read data mux and unmapped error
`timescale 1ns/1ps

module periph_decoder
  import board_cfg_pkg::*;
  import board_regs_pkg::*;
(
  input  logic                 acc_valid_i,
  input  logic                 acc_we_i,
  input  logic [AddrWidth-1:0] acc_addr_i,
  input  logic [DataWidth-1:0] acc_wdata_i,
  output logic [DataWidth-1:0] acc_rdata_o,
  output logic                 acc_err_o,
  // Peers
  input  logic [DataWidth-1:0] boot_rdata_i,
  input  logic [DataWidth-1:0] fan_rdata_i,
  input  logic [DataWidth-1:0] rtc_rdata_i,
  output logic                 boot_we_o,
  output logic                 fan_we_o,
  output logic                 rtc_clr_o,
  output logic [7:0]           wr_data_o
);

  logic [AddrWidth-3:0] word_addr;
  logic                 wr_req;
  logic                 miss;

  // Byte offset bits are ignored
  assign word_addr = acc_addr_i[AddrWidth-1:2];
  assign wr_req    = acc_valid_i & acc_we_i;
  assign wr_data_o = acc_wdata_i[7:0];

  always_comb begin
    acc_rdata_o = ErrWord;
    miss        = 1'b0;
    boot_we_o   = 1'b0;
    fan_we_o    = 1'b0;
    rtc_clr_o   = 1'b0;
    case (word_addr)
      RegIdOffs[AddrWidth-1:2]: begin
        // Identity is read only
        if (acc_we_i) begin
          miss = 1'b1;
        end else begin
          acc_rdata_o = BoardIdWord;
        end
      end
      RegBootOffs[AddrWidth-1:2]: begin
        acc_rdata_o = boot_rdata_i;
        boot_we_o   = wr_req;
      end
      RegFanOffs[AddrWidth-1:2]: begin
        acc_rdata_o = fan_rdata_i;
        fan_we_o    = wr_req;
      end
      RegRtcOffs[AddrWidth-1:2]: begin
        acc_rdata_o = rtc_rdata_i;
        rtc_clr_o   = wr_req;
      end
      default: begin
        miss = 1'b1;
      end
    endcase
  end

  assign acc_err_o = acc_valid_i & miss;

endmodule

//--- logic/rtc_divider.sv
// RTC clock divider from soc_clk with a clearable count of RTC rising edges
`timescale 1ns/1ps

module rtc_divider
  import board_cfg_pkg::*;
(
  input  logic                 soc_clk,
  input  logic                 rst_n,
  input  logic                 rtc_clr_i,
  output logic                 rtc_o,
  output logic [DataWidth-1:0] rtc_count_o
);

  logic [RtcCntWidth-1:0] div_cnt_q;
  logic                   div_wrap;
  logic                   rtc_q;
  logic                   rtc_prev_q;
  logic                   rtc_rise;
  logic [DataWidth-1:0]   edge_cnt_q;

  //////////////////////////////////////////////////////////////////////
  // Divider
  //////////////////////////////////////////////////////////////////////

  assign div_wrap = (div_cnt_q == RtcCntWidth'(RtcHalfPeriod - 1));

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      div_cnt_q <= '0;
      rtc_q     <= 1'b0;
    end else if (div_wrap) begin
      div_cnt_q <= '0;
      rtc_q     <= ~rtc_q;
    end else begin
      div_cnt_q <= div_cnt_q + 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Edge counter
  //////////////////////////////////////////////////////////////////////

  // Rise seen one cycle after rtc_o goes high
  assign rtc_rise = rtc_q & ~rtc_prev_q;

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      rtc_prev_q <= 1'b0;
      edge_cnt_q <= '0;
    end else begin
      rtc_prev_q <= rtc_q;
      if (rtc_clr_i) begin
        edge_cnt_q <= '0;
      end else if (rtc_rise) begin
        edge_cnt_q <= edge_cnt_q + 1'b1;
      end
    end
  end

  assign rtc_o       = rtc_q;
  assign rtc_count_o = edge_cnt_q;

endmodule

//--- logic/fan_ctrl.sv
// Fan PWM generator with duty from board switches or a register override
`timescale 1ns/1ps

module fan_ctrl
  import board_cfg_pkg::*;
(
  input  logic                    soc_clk,
  input  logic                    rst_n,
  input  logic [FanDutyWidth-1:0] fan_sw_i,
  input  logic                    fan_we_i,
  input  logic [7:0]              wr_data_i,
  output logic                    fan_pwm_o,
  output logic [DataWidth-1:0]    fan_rdata_o
);

  logic                     ovr_q;
  logic [FanDutyWidth-1:0]  duty_q;
  logic [FanDutyWidth-1:0]  duty_eff;
  logic [FanPrescWidth-1:0] presc_q;
  logic                     presc_wrap;
  logic [FanDutyWidth-1:0]  step_q;
  logic                     pwm_q;

  //////////////////////////////////////////////////////////////////////
  // Control register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      ovr_q  <= 1'b0;
      duty_q <= '0;
    end else if (fan_we_i) begin
      ovr_q  <= wr_data_i[FanDutyWidth];
      duty_q <= wr_data_i[FanDutyWidth-1:0];
    end
  end

  assign duty_eff = ovr_q ? duty_q : fan_sw_i;

  //////////////////////////////////////////////////////////////////////
  // PWM
  //////////////////////////////////////////////////////////////////////

  assign presc_wrap = (presc_q == FanPrescWidth'(FanPrescale - 1));

  // Step counter wraps on its own after 16 steps
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      presc_q <= '0;
      step_q  <= '0;
      pwm_q   <= 1'b0;
    end else begin
      if (presc_wrap) begin
        presc_q <= '0;
        step_q  <= step_q + 1'b1;
      end else begin
        presc_q <= presc_q + 1'b1;
      end
      pwm_q <= (step_q < duty_eff);
    end
  end

  assign fan_pwm_o = pwm_q;

  // Effective duty in bits 11:8, register fields in 4:0
  assign fan_rdata_o = {{(DataWidth-12){1'b0}}, duty_eff, 3'b000, ovr_q, duty_q};

endmodule

//--- logic/boot_ctrl.sv
// Boot mode register with selection between board pins and register override
`timescale 1ns/1ps

module boot_ctrl
  import board_cfg_pkg::*;
(
  input  logic                     soc_clk,
  input  logic                     rst_n,
  input  logic [BootModeWidth-1:0] boot_mode_i,
  input  logic                     boot_we_i,
  input  logic [7:0]               wr_data_i,
  output logic [BootModeWidth-1:0] boot_mode_o,
  output logic [DataWidth-1:0]     boot_rdata_o
);

  logic                     sel_q;
  logic [BootModeWidth-1:0] mode_q;

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      sel_q  <= 1'b0;
      mode_q <= '0;
    end else if (boot_we_i) begin
      sel_q  <= wr_data_i[BootModeWidth];
      mode_q <= wr_data_i[BootModeWidth-1:0];
    end
  end

  // Override wins once selected
  assign boot_mode_o = sel_q ? mode_q : boot_mode_i;

  // Pins in 17:16, effective mode in 9:8, register in 2:0
  assign boot_rdata_o = {
    {(DataWidth-18){1'b0}},
    boot_mode_i,
    6'b000000,
    boot_mode_o,
    5'b00000,
    sel_q,
    mode_q
  };

endmodule

//--- logic/board_shell_top.sv
// Board control shell top with AXI4-Lite port, address decoder and peripherals
`timescale 1ns/1ps

module board_shell_top
  import board_cfg_pkg::*;
(
  input  logic                     soc_clk,
  input  logic                     rst_n,
  // AXI4-Lite slave
  input  logic [AddrWidth-1:0]     axil_awaddr_i,
  input  logic                     axil_awvalid_i,
  output logic                     axil_awready_o,
  input  logic [DataWidth-1:0]     axil_wdata_i,
  input  logic [DataWidth/8-1:0]   axil_wstrb_i,
  input  logic                     axil_wvalid_i,
  output logic                     axil_wready_o,
  output logic [1:0]               axil_bresp_o,
  output logic                     axil_bvalid_o,
  input  logic                     axil_bready_i,
  input  logic [AddrWidth-1:0]     axil_araddr_i,
  input  logic                     axil_arvalid_i,
  output logic                     axil_arready_o,
  output logic [DataWidth-1:0]     axil_rdata_o,
  output logic [1:0]               axil_rresp_o,
  output logic                     axil_rvalid_o,
  input  logic                     axil_rready_i,
  // Board pins
  input  logic [BootModeWidth-1:0] boot_mode_i,
  input  logic [FanDutyWidth-1:0]  fan_sw_i,
  output logic [BootModeWidth-1:0] boot_mode_o,
  output logic                     fan_pwm_o,
  output logic                     rtc_o
);

  logic                 acc_valid;
  logic                 acc_we;
  logic [AddrWidth-1:0] acc_addr;
  logic [DataWidth-1:0] acc_wdata;
  logic [DataWidth-1:0] acc_rdata;
  logic                 acc_err;
  logic                 boot_we;
  logic                 fan_we;
  logic                 rtc_clr;
  logic [7:0]           wr_data;
  logic [DataWidth-1:0] boot_rdata;
  logic [DataWidth-1:0] fan_rdata;
  logic [DataWidth-1:0] rtc_rdata;

  //////////////////////////////////////////////////////////////////////
  // Bus port and decoder
  //////////////////////////////////////////////////////////////////////

  axil_slave_port i_axil_slave_port (
    .soc_clk        ( soc_clk        ),
    .rst_n          ( rst_n          ),
    .axil_awaddr_i  ( axil_awaddr_i  ),
    .axil_awvalid_i ( axil_awvalid_i ),
    .axil_awready_o ( axil_awready_o ),
    .axil_wdata_i   ( axil_wdata_i   ),
    .axil_wstrb_i   ( axil_wstrb_i   ),
    .axil_wvalid_i  ( axil_wvalid_i  ),
    .axil_wready_o  ( axil_wready_o  ),
    .axil_bresp_o   ( axil_bresp_o   ),
    .axil_bvalid_o  ( axil_bvalid_o  ),
    .axil_bready_i  ( axil_bready_i  ),
    .axil_araddr_i  ( axil_araddr_i  ),
    .axil_arvalid_i ( axil_arvalid_i ),
    .axil_arready_o ( axil_arready_o ),
    .axil_rdata_o   ( axil_rdata_o   ),
    .axil_rresp_o   ( axil_rresp_o   ),
    .axil_rvalid_o  ( axil_rvalid_o  ),
    .axil_rready_i  ( axil_rready_i  ),
    .acc_valid_o    ( acc_valid      ),
    .acc_we_o       ( acc_we         ),
    .acc_addr_o     ( acc_addr       ),
    .acc_wdata_o    ( acc_wdata      ),
    .acc_rdata_i    ( acc_rdata      ),
    .acc_err_i      ( acc_err        )
  );

  periph_decoder i_periph_decoder (
    .acc_valid_i  ( acc_valid  ),
    .acc_we_i     ( acc_we     ),
    .acc_addr_i   ( acc_addr   ),
    .acc_wdata_i  ( acc_wdata  ),
    .acc_rdata_o  ( acc_rdata  ),
    .acc_err_o    ( acc_err    ),
    .boot_rdata_i ( boot_rdata ),
    .fan_rdata_i  ( fan_rdata  ),
    .rtc_rdata_i  ( rtc_rdata  ),
    .boot_we_o    ( boot_we    ),
    .fan_we_o     ( fan_we     ),
    .rtc_clr_o    ( rtc_clr    ),
    .wr_data_o    ( wr_data    )
  );

  //////////////////////////////////////////////////////////////////////
  // Peripherals
  //////////////////////////////////////////////////////////////////////

  rtc_divider i_rtc_divider (
    .soc_clk     ( soc_clk   ),
    .rst_n       ( rst_n     ),
    .rtc_clr_i   ( rtc_clr   ),
    .rtc_o       ( rtc_o     ),
    .rtc_count_o ( rtc_rdata )
  );

  fan_ctrl i_fan_ctrl (
    .soc_clk     ( soc_clk   ),
    .rst_n       ( rst_n     ),
    .fan_sw_i    ( fan_sw_i  ),
    .fan_we_i    ( fan_we    ),
    .wr_data_i   ( wr_data   ),
    .fan_pwm_o   ( fan_pwm_o ),
    .fan_rdata_o ( fan_rdata )
  );

  boot_ctrl i_boot_ctrl (
    .soc_clk      ( soc_clk     ),
    .rst_n        ( rst_n       ),
    .boot_mode_i  ( boot_mode_i ),
    .boot_we_i    ( boot_we     ),
    .wr_data_i    ( wr_data     ),
    .boot_mode_o  ( boot_mode_o ),
    .boot_rdata_o ( boot_rdata  )
  );

endmodule

//--- verif/board_shell_props.sv
// AXI4-Lite handshake assertions bound to the slave port
`timescale 1ns/1ps

module board_shell_props
  import board_cfg_pkg::*;
(
  input logic                 soc_clk,
  input logic                 rst_n,
  input logic                 awready_i,
  input logic                 wready_i,
  input logic [1:0]           bresp_i,
  input logic                 bvalid_i,
  input logic                 bready_i,
  input logic [DataWidth-1:0] rdata_i,
  input logic [1:0]           rresp_i,
  input logic                 rvalid_i,
  input logic                 rready_i
);

  // Number of failed handshake properties
  int unsigned fail_cnt = 0;

  // Write response held under back-pressure
  b_hold: assert property (@(posedge soc_clk) disable iff (!rst_n)
    (bvalid_i && !bready_i) |=> (bvalid_i && $stable(bresp_i)))
    else begin
      $error("bvalid or bresp changed before bready");
      fail_cnt++;
    end

  // Read response held under back-pressure
  r_hold: assert property (@(posedge soc_clk) disable iff (!rst_n)
    (rvalid_i && !rready_i) |=> (rvalid_i && $stable(rdata_i) && $stable(rresp_i)))
    else begin
      $error("rvalid, rdata or rresp changed before rready");
      fail_cnt++;
    end

  aw_w_same: assert property (@(posedge soc_clk) disable iff (!rst_n)
    awready_i == wready_i)
    else begin
      $error("awready and wready differ");
      fail_cnt++;
    end

  // First cycle out of reset
  rst_quiet: assert property (@(posedge soc_clk)
    $rose(rst_n) |-> (!bvalid_i && !rvalid_i))
    else begin
      $error("response valid right after reset");
      fail_cnt++;
    end

endmodule

bind axil_slave_port board_shell_props i_board_shell_props (
  .soc_clk   ( soc_clk        ),
  .rst_n     ( rst_n          ),
  .awready_i ( axil_awready_o ),
  .wready_i  ( axil_wready_o  ),
  .bresp_i   ( axil_bresp_o   ),
  .bvalid_i  ( axil_bvalid_o  ),
  .bready_i  ( axil_bready_i  ),
  .rdata_i   ( axil_rdata_o   ),
  .rresp_i   ( axil_rresp_o   ),
  .rvalid_i  ( axil_rvalid_o  ),
  .rready_i  ( axil_rready_i  )
);

//--- verif/board_shell_tb.sv
// Testbench for the board control shell, register patterns plus RTC and fan timing
`timescale 1ns/1ps

module board_shell_tb
  import board_cfg_pkg::*;
  import board_regs_pkg::*;
;

  localparam int MaxLines = 64;
  localparam int PatCols  = 5;
  localparam int PwmCycles = 16 * FanPrescale;

  logic                     soc_clk;
  logic                     rst_n;
  logic [AddrWidth-1:0]     awaddr;
  logic                     awvalid;
  logic                     awready;
  logic [DataWidth-1:0]     wdata;
  logic [DataWidth/8-1:0]   wstrb;
  logic                     wvalid;
  logic                     wready;
  logic [1:0]               bresp;
  logic                     bvalid;
  logic                     bready;
  logic [AddrWidth-1:0]     araddr;
  logic                     arvalid;
  logic                     arready;
  logic [DataWidth-1:0]     rdata;
  logic [1:0]               rresp;
  logic                     rvalid;
  logic                     rready;
  logic [BootModeWidth-1:0] boot_pins;
  logic [FanDutyWidth-1:0]  fan_sw;
  logic [BootModeWidth-1:0] boot_mode;
  logic                     fan_pwm;
  logic                     rtc;

  // Five words per line for op, address, write data, response and read data
  logic [31:0] pat_mem [0:MaxLines*PatCols-1];
  int          line_cnt;
  logic        load_done;

  board_shell_top i_board_shell_top (
    .soc_clk        ( soc_clk   ),
    .rst_n          ( rst_n     ),
    .axil_awaddr_i  ( awaddr    ),
    .axil_awvalid_i ( awvalid   ),
    .axil_awready_o ( awready   ),
    .axil_wdata_i   ( wdata     ),
    .axil_wstrb_i   ( wstrb     ),
    .axil_wvalid_i  ( wvalid    ),
    .axil_wready_o  ( wready    ),
    .axil_bresp_o   ( bresp     ),
    .axil_bvalid_o  ( bvalid    ),
    .axil_bready_i  ( bready    ),
    .axil_araddr_i  ( araddr    ),
    .axil_arvalid_i ( arvalid   ),
    .axil_arready_o ( arready   ),
    .axil_rdata_o   ( rdata     ),
    .axil_rresp_o   ( rresp     ),
    .axil_rvalid_o  ( rvalid    ),
    .axil_rready_i  ( rready    ),
    .boot_mode_i    ( boot_pins ),
    .fan_sw_i       ( fan_sw    ),
    .boot_mode_o    ( boot_mode ),
    .fan_pwm_o      ( fan_pwm   ),
    .rtc_o          ( rtc       )
  );

  initial begin
    soc_clk = 1'b0;
    forever #5 soc_clk = ~soc_clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Result checks
  //////////////////////////////////////////////////////////////////////

  task automatic fail_run(input string why);
    $display("Test failed");
    $fatal(1, "%s", why);
  endtask

  task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
    if (got !== exp) begin
      $display("error %s: got 0x%0h, expected 0x%0h", name, got, exp);
      fail_run("response mismatch");
    end
  endtask

  task automatic check_word(input string name, input logic [DataWidth-1:0] got,
                            input logic [DataWidth-1:0] exp);
    if (got !== exp) begin
      $display("error %s: got 0x%0h, expected 0x%0h", name, got, exp);
      fail_run("data mismatch");
    end
  endtask

  task automatic check_mode(input string name, input logic [BootModeWidth-1:0] got,
                            input logic [BootModeWidth-1:0] exp);
    if (got !== exp) begin
      $display("error %s: got 0x%0h, expected 0x%0h", name, got, exp);
      fail_run("boot mode mismatch");
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("error %s: got 0x%0h, expected 0x%0h", name, got, exp);
      fail_run("cycle count mismatch");
    end
  endtask

  // Failures of the bound handshake properties
  always @(negedge soc_clk) begin
    if (i_board_shell_top.i_axil_slave_port.i_board_shell_props.fail_cnt != 0) begin
      fail_run("AXI4-Lite handshake assertion failed");
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Bus access
  //////////////////////////////////////////////////////////////////////

  // Inputs change just after the rising edge
  task automatic next_cycle();
    @(posedge soc_clk);
    #1;
  endtask

  task automatic do_write(input logic [AddrWidth-1:0] addr, input logic [DataWidth-1:0] data,
                          input logic [DataWidth/8-1:0] strb, input logic [1:0] exp_resp);
    int stall;
    stall = $urandom % 7;
    next_cycle();
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    @(negedge soc_clk);
    // Address and data are taken in the same cycle
    while (!(awready && wready)) @(negedge soc_clk);
    next_cycle();
    awvalid = 1'b0;
    wvalid  = 1'b0;
    // Hold off bready so the response must wait
    repeat (stall) next_cycle();
    @(negedge soc_clk);
    while (!bvalid) @(negedge soc_clk);
    check_resp("bresp", bresp, exp_resp);
    next_cycle();
    bready = 1'b1;
    next_cycle();
    bready = 1'b0;
  endtask

  task automatic do_read(input logic [AddrWidth-1:0] addr, input logic [1:0] exp_resp,
                         input logic [DataWidth-1:0] exp_data);
    int stall;
    stall = $urandom % 7;
    next_cycle();
    araddr  = addr;
    arvalid = 1'b1;
    @(negedge soc_clk);
    while (!arready) @(negedge soc_clk);
    next_cycle();
    arvalid = 1'b0;
    repeat (stall) next_cycle();
    @(negedge soc_clk);
    while (!rvalid) @(negedge soc_clk);
    check_resp("rresp", rresp, exp_resp);
    check_word("rdata", rdata, exp_data);
    next_cycle();
    rready = 1'b1;
    next_cycle();
    rready = 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Fan and RTC measurement
  //////////////////////////////////////////////////////////////////////

  task automatic measure_fan(input int exp_high);
    int high;
    // Let a new duty reach the PWM output
    repeat (3) next_cycle();
    high = 0;
    repeat (4 * PwmCycles) begin
      @(negedge soc_clk);
      if (fan_pwm) high++;
    end
    check_count("fan_pwm_o high cycles", high, exp_high);
  endtask

  task automatic wait_rtc_rise();
    while (rtc !== 1'b0) @(negedge soc_clk);
    while (rtc !== 1'b1) @(negedge soc_clk);
  endtask

  task automatic measure_rtc();
    int   cnt;
    logic prev;
    @(negedge soc_clk);
    prev = rtc;
    while (rtc === prev) @(negedge soc_clk);
    cnt  = 0;
    prev = rtc;
    while (rtc === prev) begin
      @(negedge soc_clk);
      cnt++;
    end
    check_count("rtc_o half period", cnt, RtcHalfPeriod);
    // Rising edge to rising edge
    wait_rtc_rise();
    cnt = 0;
    while (rtc !== 1'b0) begin
      @(negedge soc_clk);
      cnt++;
    end
    while (rtc !== 1'b1) begin
      @(negedge soc_clk);
      cnt++;
    end
    check_count("rtc_o period", cnt, 2 * RtcHalfPeriod);
  endtask

  // Clear well after an edge, then read well clear of the next one
  task automatic rtc_count_test(input int edges);
    int seen;
    wait_rtc_rise();
    repeat (5) next_cycle();
    do_write(RegRtcOffs, '0, 4'hF, RespOkay);
    seen = 0;
    while (seen < edges) begin
      wait_rtc_rise();
      seen++;
    end
    repeat (10) next_cycle();
    do_read(RegRtcOffs, RespOkay, DataWidth'(edges));
  endtask

  //////////////////////////////////////////////////////////////////////
  // Pattern replay
  //////////////////////////////////////////////////////////////////////

  task automatic run_line(input int idx);
    logic [31:0] op;
    logic [31:0] addr;
    logic [31:0] wd;
    logic [31:0] resp;
    logic [31:0] rd;
    op   = pat_mem[idx*PatCols];
    addr = pat_mem[idx*PatCols+1];
    wd   = pat_mem[idx*PatCols+2];
    resp = pat_mem[idx*PatCols+3];
    rd   = pat_mem[idx*PatCols+4];
    case (op)
      32'h0: do_read(addr[AddrWidth-1:0], resp[1:0], rd);
      32'h1: do_write(addr[AddrWidth-1:0], wd, 4'hF, resp[1:0]);
      32'h2: do_write(addr[AddrWidth-1:0], wd, 4'hE, resp[1:0]);
      32'h3: begin
        next_cycle();
        boot_pins = wd[BootModeWidth-1:0];
        fan_sw    = wd[8 +: FanDutyWidth];
      end
      32'h4: begin
        @(negedge soc_clk);
        check_mode("boot_mode_o", boot_mode, rd[BootModeWidth-1:0]);
      end
      32'h5: measure_fan(int'(rd));
      default: fail_run("unknown opcode in pattern file");
    endcase
  endtask

  initial begin
    int limit;
    wait (load_done === 1'b1);
    limit = line_cnt * 40 + 20 * PwmCycles + 10 * 2 * RtcHalfPeriod + 5;
    repeat (limit) @(posedge soc_clk);
    $display("Watchdog expired after %0d cycles, the run hung", limit);
    fail_run("timeout");
  end

  initial begin
    void'($urandom(32'hacd2b42c));
    rst_n     = 1'b0;
    awaddr    = '0;
    awvalid   = 1'b0;
    wdata     = '0;
    wstrb     = '0;
    wvalid    = 1'b0;
    bready    = 1'b0;
    araddr    = '0;
    arvalid   = 1'b0;
    rready    = 1'b0;
    boot_pins = '0;
    fan_sw    = '0;
    load_done = 1'b0;
    $readmemh("verif/board_shell_patterns.txt", pat_mem);
    line_cnt = 0;
    while (line_cnt < MaxLines && pat_mem[line_cnt*PatCols] !== 32'hF) line_cnt++;
    if (line_cnt == MaxLines) begin
      fail_run("pattern file has no end marker");
    end
    load_done = 1'b1;
    repeat (5) @(posedge soc_clk);
    #1;
    rst_n = 1'b1;
    for (int i = 0; i < line_cnt; i++) begin
      run_line(i);
    end
    measure_rtc();
    rtc_count_test(3);
    if (i_board_shell_top.i_axil_slave_port.i_board_shell_props.fail_cnt != 0) begin
      fail_run("AXI4-Lite handshake assertion failed");
    end else begin
      $display("Test passed");
      $finish;
    end
  end

endmodule

//--- verif/board_shell_patterns.txt
// op addr wdata resp rdata, op 0 read, 1 write, 2 write with strobe 0 low,
// 3 set pins (wdata 11:8 fan switches, 1:0 boot pins), 4 check boot mode, 5 fan high cycles, f end
0 00 00000000 0 5abc0001
0 10 00000000 2 badcab1e
0 fc 00000000 2 badcab1e
1 00 12345678 2 00000000
1 20 00000001 2 00000000
3 00 00000302 0 00000000
4 00 00000000 0 00000002
0 04 00000000 0 00020200
5 00 00000000 0 00000030
0 08 00000000 0 00000300
1 04 00000005 0 00000000
4 00 00000000 0 00000001
0 04 00000000 0 00020105
3 00 00000303 0 00000000
4 00 00000000 0 00000001
0 04 00000000 0 00030105
2 04 00000006 0 00000000
0 04 00000000 0 00030105
4 00 00000000 0 00000001
1 04 00000000 0 00000000
4 00 00000000 0 00000003
0 04 00000000 0 00030300
1 08 0000001a 0 00000000
5 00 00000000 0 000000a0
0 08 00000000 0 00000a1a
1 08 00000010 0 00000000
5 00 00000000 0 00000000
0 08 00000000 0 00000010
1 08 0000000f 0 00000000
5 00 00000000 0 00000030
0 08 00000000 0 0000030f
3 00 00000f00 0 00000000
4 00 00000000 0 00000000
5 00 00000000 0 000000f0
0 08 00000000 0 00000f0f
f 00 00000000 0 00000000

//--- board_shell_top.f
logic/board_cfg_pkg.sv
logic/board_regs_pkg.sv
logic/axil_slave_port.sv
logic/periph_decoder.sv
logic/rtc_divider.sv
logic/fan_ctrl.sv
logic/boot_ctrl.sv
logic/board_shell_top.sv
verif/board_shell_props.sv
verif/board_shell_tb.sv
